/* files.f */
+incdir+hw
hw/fcore_pkg.sv
hw/program_memory.sv
hw/efi_sqrt.sv
hw/control_unit.sv
hw/fcore_control_top.sv
sim/tb_fcore_control.sv

/* hw/control_unit.sv */
// Sequencer FSM of the front end
// Every instruction is issued once per active channel before the program counter moves
// n_channels must be at least 1
// n_channels and program_size are sampled live and must hold steady during a run
// An EFI call reserves a stream credit before it starts, so its beat never waits
// Fault is sticky and only rst clears it

`default_nettype none

`include "fcore_cfg.svh"

module control_unit (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    run,
    input  fcore_pkg::channel_t     n_channels,
    input  fcore_pkg::pc_t          program_size,
    input  logic                    credit_return,
    input  logic                    efi_done,
    input  fcore_pkg::efi_result_t  efi_result,
    input  fcore_pkg::instr_t       word_lo,
    input  fcore_pkg::instr_t       word_hi,
    output fcore_pkg::pc_t          fetch_addr,
    output logic                    loader_ready,
    output logic                    efi_start,
    output fcore_pkg::efi_operand_t efi_operand,
    output logic                    instr_valid,
    output fcore_pkg::instr_t       instr_data,
    output fcore_pkg::instr_t       instr_const,
    output fcore_pkg::channel_t     instr_channel,
    output fcore_pkg::pc_t          instr_pc,
    output logic                    done,
    output logic                    fault
);

    localparam int CREDIT_W = $clog2(`FCORE_STREAM_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`FCORE_STREAM_CREDITS);

    fcore_pkg::ctrl_state_t state;
    fcore_pkg::pc_t         pc;
    fcore_pkg::channel_t    channel;
    logic [CREDIT_W-1:0]    credit_count;

    fcore_pkg::opcode_t opcode;
    logic               is_ldc;
    logic               is_efi;
    logic               is_stop;
    logic               has_credit;
    logic               last_channel;
    logic               issue_beat;

    // The decode of the word at pc is valid from the ISSUE state on
    assign opcode  = fcore_pkg::opcode_t'(word_lo[`FCORE_OPCODE_WIDTH-1:0]);
    assign is_ldc  = opcode == fcore_pkg::LDC;
    assign is_efi  = opcode == fcore_pkg::EFI;
    assign is_stop = opcode == fcore_pkg::STOP;

    assign has_credit   = credit_count != '0;
    assign last_channel = channel == fcore_pkg::channel_t'(n_channels - 1'b1);

    // EFI beats go out straight from EFI_WAIT using the credit held since the call
    assign issue_beat = (state == fcore_pkg::ISSUE && has_credit && !is_stop && !is_efi)
                      || (state == fcore_pkg::EFI_WAIT && efi_done);

    assign fetch_addr   = pc;
    assign efi_operand  = word_lo[31:16];
    assign loader_ready = state == fcore_pkg::IDLE;
    assign fault        = state == fcore_pkg::FAULT;

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= fcore_pkg::IDLE;
            pc        <= '0;
            channel   <= '0;
            efi_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            efi_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                fcore_pkg::IDLE: begin
                    if (run) begin
                        pc      <= '0;
                        channel <= '0;
                        state   <= fcore_pkg::FETCH;
                    end
                end
                fcore_pkg::FETCH: begin
                    // Running off the end of the program without a STOP is fatal
                    if (pc >= program_size) begin
                        state <= fcore_pkg::FAULT;
                    end else begin
                        state <= fcore_pkg::ISSUE;
                    end
                end
                fcore_pkg::ISSUE: begin
                    if (is_stop) begin
                        done  <= 1'b1;
                        state <= fcore_pkg::IDLE;
                    end else if (is_efi && has_credit) begin
                        efi_start <= 1'b1;
                        state     <= fcore_pkg::EFI_WAIT;
                    end
                end
                fcore_pkg::EFI_WAIT: begin
                    // Left through the beat advance below once efi_done arrives
                end
                fcore_pkg::FAULT: begin
                    state <= fcore_pkg::FAULT;
                end
                default: begin
                    state <= fcore_pkg::IDLE;
                end
            endcase

            // Plain, LDC and EFI beats share the channel and program counter advance
            if (issue_beat) begin
                if (last_channel) begin
                    channel <= '0;
                    pc      <= pc + (is_ldc ? fcore_pkg::pc_t'(2) : fcore_pkg::pc_t'(1));
                    state   <= fcore_pkg::FETCH;
                end else begin
                    channel <= channel + 1'b1;
                    state   <= fcore_pkg::ISSUE;
                end
            end
        end
    end

    // A return in the same cycle as an issue cancels out
    always_ff @(posedge clock) begin
        if (rst) begin
            credit_count <= CREDIT_MAX;
        end else begin
            case ({issue_beat, credit_return})
                2'b10: credit_count <= credit_count - 1'b1;
                2'b01: credit_count <= credit_count + 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= issue_beat;
        end
    end

    // The root replaces the upper half of an EFI word in the beat payload
    always_ff @(posedge clock) begin
        if (issue_beat) begin
            if (is_efi) begin
                instr_data <= {fcore_pkg::efi_operand_t'(efi_result), word_lo[15:0]};
            end else begin
                instr_data <= word_lo;
            end
            instr_const   <= is_ldc ? word_hi : '0;
            instr_channel <= channel;
            instr_pc      <= pc;
        end
    end

    // Too many returns push the count above the limit and a wrap below zero lands there too
    a_credit_range: assert property (
        @(posedge clock) disable iff (rst) credit_count <= CREDIT_MAX
    );

    a_valid_has_credit: assert property (
        @(posedge clock) disable iff (rst) instr_valid |-> $past(credit_count) != '0
    );

    a_done_fault_excl: assert property (
        @(posedge clock) disable iff (rst) !(done && fault)
    );

endmodule

`default_nettype wire

/* hw/efi_sqrt.sv */
// Iterative floor square root of a 16-bit operand
// One result bit per cycle, efi_done pulses eight cycles after efi_start
// efi_result holds until the next start, and a new start must wait for efi_done

`default_nettype none

module efi_sqrt (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    efi_start,
    input  fcore_pkg::efi_operand_t efi_operand,
    output logic                    efi_done,
    output fcore_pkg::efi_result_t  efi_result
);

    logic                   busy;
    logic [2:0]             step;
    fcore_pkg::efi_operand_t op_q;
    logic [11:0]            rem_q;
    fcore_pkg::efi_result_t root_q;

    logic [11:0] rem_shift;
    logic [11:0] trial;
    logic        fits;

    // Bring down the next two operand bits and try a 1 in the next root bit
    assign rem_shift = {rem_q[9:0], op_q[15:14]};
    assign trial     = {2'b00, root_q, 2'b01};
    assign fits      = rem_shift >= trial;

    assign efi_result = root_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy     <= 1'b0;
            step     <= '0;
            efi_done <= 1'b0;
        end else begin
            efi_done <= 1'b0;
            if (efi_start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == 3'd7) begin
                    busy     <= 1'b0;
                    efi_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (efi_start) begin
            op_q   <= efi_operand;
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy) begin
            op_q   <= {op_q[13:0], 2'b00};
            // Restore the remainder when the trial bit does not fit
            rem_q  <= fits ? rem_shift - trial : rem_shift;
            root_q <= {root_q[6:0], fits};
        end
    end

    // The sequencer must never call again before the previous root is out
    a_no_start_while_busy: assert property (
        @(posedge clock) disable iff (rst) efi_start |-> !busy
    );

endmodule

`default_nettype wire

/* hw/fcore_cfg.svh */
// Build-time configuration of the sequencer front end
// The channel width is derived from FCORE_MAX_CHANNELS with $clog2, so a power of two
// gives the cleanest counters
// FCORE_STREAM_CREDITS must match the beat buffer depth of the execution back end

`ifndef FCORE_CFG_SVH
`define FCORE_CFG_SVH

// Program address width, the instruction memory holds 2**FCORE_PC_WIDTH words
`define FCORE_PC_WIDTH 10

// One program word
`define FCORE_INSTR_WIDTH 32

// The opcode sits in the low bits of every program word
`define FCORE_OPCODE_WIDTH 5

// Upper bound on the number of active channels
`define FCORE_MAX_CHANNELS 16

// Beats the back end can hold before it must return a credit
`define FCORE_STREAM_CREDITS 4

`endif

/* hw/fcore_control_top.sv */
// Top level of the sequencer front end, memory, FSM and square-root unit
// Adds no registers, all stream and status timing is that of control_unit
// Loader writes are dropped unless loader_ready is high

`default_nettype none

module fcore_control_top (
    input  logic                clock,
    input  logic                rst,
    input  logic                run,
    input  fcore_pkg::channel_t n_channels,
    input  fcore_pkg::pc_t      program_size,
    input  logic                load_en,
    input  fcore_pkg::pc_t      load_addr,
    input  fcore_pkg::instr_t   load_data,
    input  logic                credit_return,
    output logic                loader_ready,
    output logic                instr_valid,
    output fcore_pkg::instr_t   instr_data,
    output fcore_pkg::instr_t   instr_const,
    output fcore_pkg::channel_t instr_channel,
    output fcore_pkg::pc_t      instr_pc,
    output logic                done,
    output logic                fault
);

    fcore_pkg::pc_t          fetch_addr;
    fcore_pkg::instr_t       word_lo;
    fcore_pkg::instr_t       word_hi;
    logic                    efi_start;
    fcore_pkg::efi_operand_t efi_operand;
    logic                    efi_done;
    fcore_pkg::efi_result_t  efi_result;
    logic                    mem_load_en;

    assign mem_load_en = load_en && loader_ready;

    program_memory u_program_memory (
        .clock      (clock),
        .load_en    (mem_load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .word_lo    (word_lo),
        .word_hi    (word_hi)
    );

    control_unit u_control_unit (
        .clock         (clock),
        .rst           (rst),
        .run           (run),
        .n_channels    (n_channels),
        .program_size  (program_size),
        .credit_return (credit_return),
        .efi_done      (efi_done),
        .efi_result    (efi_result),
        .word_lo       (word_lo),
        .word_hi       (word_hi),
        .fetch_addr    (fetch_addr),
        .loader_ready  (loader_ready),
        .efi_start     (efi_start),
        .efi_operand   (efi_operand),
        .instr_valid   (instr_valid),
        .instr_data    (instr_data),
        .instr_const   (instr_const),
        .instr_channel (instr_channel),
        .instr_pc      (instr_pc),
        .done          (done),
        .fault         (fault)
    );

    efi_sqrt u_efi_sqrt (
        .clock       (clock),
        .rst         (rst),
        .efi_start   (efi_start),
        .efi_operand (efi_operand),
        .efi_done    (efi_done),
        .efi_result  (efi_result)
    );

endmodule

`default_nettype wire

/* hw/fcore_pkg.sv */
// Shared types of the sequencer front end
// Opcode values outside opcode_t are legal and run as ordinary instructions

`default_nettype none

`include "fcore_cfg.svh"

package fcore_pkg;

    typedef logic [`FCORE_PC_WIDTH-1:0] pc_t;

    typedef logic [`FCORE_INSTR_WIDTH-1:0] instr_t;

    typedef logic [$clog2(`FCORE_MAX_CHANNELS)-1:0] channel_t;

    // Square-root operand comes from the upper half of an EFI word
    typedef logic [15:0] efi_operand_t;

    typedef logic [7:0] efi_result_t;

    typedef enum logic [`FCORE_OPCODE_WIDTH-1:0] {
        NOP  = 5'h00,
        ADD  = 5'h01,
        MUL  = 5'h03,
        LDC  = 5'h0c,
        EFI  = 5'h0e,
        STOP = 5'h0f
    } opcode_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        ISSUE,
        EFI_WAIT,
        FAULT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/program_memory.sv */
// Instruction memory with one loader write port and a paired read
// Both read words are registered, so data appears one cycle after fetch_addr
// The word after the last address reads as zero, the array is not cleared by reset

`default_nettype none

`include "fcore_cfg.svh"

module program_memory (
    input  logic              clock,
    input  logic              load_en,
    input  fcore_pkg::pc_t    load_addr,
    input  fcore_pkg::instr_t load_data,
    input  fcore_pkg::pc_t    fetch_addr,
    output fcore_pkg::instr_t word_lo,
    output fcore_pkg::instr_t word_hi
);

    localparam int DEPTH = 1 << `FCORE_PC_WIDTH;

    fcore_pkg::instr_t mem [DEPTH];

    fcore_pkg::pc_t next_addr;
    logic           at_last_word;

    assign next_addr    = fcore_pkg::pc_t'(fetch_addr + 1'b1);
    assign at_last_word = fetch_addr == fcore_pkg::pc_t'(DEPTH - 1);

    // The loader only writes while the sequencer is idle
    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // The second word is the LDC constant, it is fetched with every word
    always_ff @(posedge clock) begin
        word_lo <= mem[fetch_addr];
        if (at_last_word) begin
            word_hi <= '0;
        end else begin
            word_hi <= mem[next_addr];
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the sequencer testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the testbench stops with $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fcore_control \
    -f files.f \
    -o sim_fcore_control

./obj_dir/sim_fcore_control

/* sim/tb_fcore_control.sv */
// Testbench of the sequencer front end with random programs and a random-delay stream consumer
// n_channels stays below FCORE_MAX_CHANNELS because channel_t cannot hold the limit itself
// Programs are loaded at address 0 and each run stops at the first failing check

`default_nettype none

`include "fcore_cfg.svh"

module tb_fcore_control;

    localparam int NUM_PROGRAMS    = 25;
    localparam int MAX_WORDS       = 43;
    localparam int WATCHDOG_CYCLES = 200 * MAX_WORDS * (`FCORE_MAX_CHANNELS - 1) * NUM_PROGRAMS;

    logic                clock;
    logic                rst;
    logic                run;
    fcore_pkg::channel_t n_channels;
    fcore_pkg::pc_t      program_size;
    logic                load_en;
    fcore_pkg::pc_t      load_addr;
    fcore_pkg::instr_t   load_data;
    logic                credit_return = 1'b0;
    logic                loader_ready;
    logic                instr_valid;
    fcore_pkg::instr_t   instr_data;
    fcore_pkg::instr_t   instr_const;
    fcore_pkg::channel_t instr_channel;
    fcore_pkg::pc_t      instr_pc;
    logic                done;
    logic                fault;

    fcore_pkg::instr_t prog [$];
    logic [31:0]       exp_pc [$];
    logic [31:0]       exp_ch [$];
    logic [31:0]       exp_data [$];
    logic [31:0]       exp_const [$];
    int                pending [$];
    int                kept [$];
    int                owed;
    int                outstanding;
    int                done_count;
    int                expected_done;
    string             test_name;

    fcore_control_top DUT (
        .clock         (clock),
        .rst           (rst),
        .run           (run),
        .n_channels    (n_channels),
        .program_size  (program_size),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .credit_return (credit_return),
        .loader_ready  (loader_ready),
        .instr_valid   (instr_valid),
        .instr_data    (instr_data),
        .instr_const   (instr_const),
        .instr_channel (instr_channel),
        .instr_pc      (instr_pc),
        .done          (done),
        .fault         (fault)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string field, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (expected === actual) else fail_run($sformatf(
            "ERROR %s %s: expected %h, actual %h", test_name, field, expected, actual));
    endtask

    // Reference root found by counting up through the squares
    function automatic logic [7:0] floor_sqrt(input logic [15:0] x);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= int'(x)) r++;
        return 8'(r);
    endfunction

    function automatic fcore_pkg::instr_t ordinary_word();
        fcore_pkg::instr_t w;
        w = $urandom;
        while (w[4:0] == fcore_pkg::LDC || w[4:0] == fcore_pkg::EFI
               || w[4:0] == fcore_pkg::STOP) begin
            w[4:0] = 5'($urandom_range(0, 31));
        end
        return w;
    endfunction

    task automatic make_program(input bit with_stop, input int ldc_pct, input int efi_pct,
                                input bit edge_operands);
        int                n_instr;
        int                kind;
        fcore_pkg::instr_t w;
        prog = {};
        // Extreme operands lead the program so every such test covers them
        if (edge_operands) begin
            w = $urandom;
            w[4:0] = fcore_pkg::EFI;
            w[31:16] = 16'h0000;
            prog.push_back(w);
            w[31:16] = 16'hffff;
            prog.push_back(w);
        end
        n_instr = $urandom_range(1, 20);
        for (int i = 0; i < n_instr; i++) begin
            kind = $urandom_range(0, 99);
            if (kind < ldc_pct) begin
                w = $urandom;
                w[4:0] = fcore_pkg::LDC;
                prog.push_back(w);
                prog.push_back($urandom);
            end else if (kind < ldc_pct + efi_pct) begin
                w = $urandom;
                w[4:0] = fcore_pkg::EFI;
                prog.push_back(w);
            end else begin
                prog.push_back(ordinary_word());
            end
        end
        if (with_stop) begin
            w = $urandom;
            w[4:0] = fcore_pkg::STOP;
            prog.push_back(w);
        end
    endtask

    task automatic predict_beats(input int size, input int nch);
        int                pc;
        logic [4:0]        op;
        fcore_pkg::instr_t w;
        pc = 0;
        while (pc < size) begin
            w = prog[pc];
            op = w[4:0];
            if (op == fcore_pkg::STOP) break;
            for (int ch = 0; ch < nch; ch++) begin
                exp_pc.push_back(32'(pc));
                exp_ch.push_back(32'(ch));
                if (op == fcore_pkg::EFI) begin
                    exp_data.push_back({8'h00, floor_sqrt(w[31:16]), w[15:0]});
                end else begin
                    exp_data.push_back(w);
                end
                exp_const.push_back(op == fcore_pkg::LDC ? prog[pc + 1] : 32'h0);
            end
            pc += (op == fcore_pkg::LDC) ? 2 : 1;
        end
    endtask

    task automatic load_program();
        assert (loader_ready) else fail_run("loader port is not ready while the unit is idle");
        foreach (prog[i]) begin
            @(posedge clock);
            load_en   <= 1'b1;
            load_addr <= fcore_pkg::pc_t'(i);
            load_data <= prog[i];
        end
        @(posedge clock);
        load_en <= 1'b0;
    endtask

    task automatic run_test(input string name, input bit with_stop, input int ldc_pct,
                            input int efi_pct, input bit edge_operands);
        int nch;
        int size;
        test_name = name;
        make_program(with_stop, ldc_pct, efi_pct, edge_operands);
        size = prog.size();
        nch = $urandom_range(1, `FCORE_MAX_CHANNELS - 1);
        load_program();
        predict_beats(size, nch);
        @(posedge clock);
        n_channels   <= fcore_pkg::channel_t'(nch);
        program_size <= fcore_pkg::pc_t'(size);
        run          <= 1'b1;
        @(posedge clock);
        run <= 1'b0;
        @(posedge clock);
        while (!(done || fault)) @(posedge clock);
        if (with_stop) begin
            expected_done++;
            assert (!fault) else fail_run($sformatf("%s: fault raised on a program with STOP",
                                                    test_name));
        end
        repeat (20) @(posedge clock);
        @(negedge clock);
        check_eq("missing beats", 32'h0, 32'(exp_pc.size()));
        check_eq("done pulses", 32'(expected_done), 32'(done_count));
        check_eq("fault", {31'h0, !with_stop}, {31'h0, fault});
        check_eq("loader_ready", {31'h0, with_stop}, {31'h0, loader_ready});
        if (!with_stop) begin
            // Only reset leaves the fault state
            @(posedge clock);
            rst <= 1'b1;
            repeat (5) @(posedge clock);
            rst <= 1'b0;
            @(negedge clock);
            check_eq("fault after reset", 32'h0, {31'h0, fault});
            check_eq("loader_ready after reset", 32'h1, {31'h0, loader_ready});
        end
    endtask

    // The stream consumer checks each beat in order and returns its credit after 0 to 5 cycles
    always @(posedge clock) begin
        if (rst) begin
            pending       = {};
            owed          = 0;
            outstanding   = 0;
            credit_return <= 1'b0;
        end else begin
            if (credit_return) outstanding--;
            if (instr_valid) begin
                assert (exp_pc.size() > 0) else fail_run($sformatf(
                    "%s: beat at pc %0d channel %0d was not expected",
                    test_name, instr_pc, instr_channel));
                check_eq("pc", exp_pc.pop_front(), 32'(instr_pc));
                check_eq("channel", exp_ch.pop_front(), 32'(instr_channel));
                check_eq("data", exp_data.pop_front(), instr_data);
                check_eq("const", exp_const.pop_front(), instr_const);
                outstanding++;
                assert (outstanding <= `FCORE_STREAM_CREDITS) else fail_run($sformatf(
                    "%s: %0d beats outstanding, more than the stream credits",
                    test_name, outstanding));
                pending.push_back($urandom_range(0, 5));
            end
            kept = {};
            foreach (pending[i]) begin
                if (pending[i] == 0) begin
                    owed++;
                end else begin
                    kept.push_back(pending[i] - 1);
                end
            end
            pending = kept;
            if (owed > 0) begin
                credit_return <= 1'b1;
                owed--;
            end else begin
                credit_return <= 1'b0;
            end
            if (done) done_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        fail_run("watchdog expired before all tests finished");
    end

    initial begin
        rst           = 1'b1;
        run           = 1'b0;
        n_channels    = '0;
        program_size  = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        done_count    = 0;
        expected_done = 0;
        test_name     = "reset";
        void'($urandom(37));
        repeat (5) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        for (int i = 0; i < 6; i++) run_test($sformatf("plain_%0d", i), 1'b1, 0, 0, 1'b0);
        for (int i = 0; i < 6; i++) run_test($sformatf("ldc_%0d", i), 1'b1, 40, 0, 1'b0);
        for (int i = 0; i < 6; i++) run_test($sformatf("efi_%0d", i), 1'b1, 0, 40, 1'b1);
        for (int i = 0; i < 6; i++) run_test($sformatf("credits_%0d", i), 1'b1, 20, 20, 1'b0);
        run_test("fault_0", 1'b0, 20, 20, 1'b0);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
